/* include/lsu_cfg.svh */
// lsu configuration: data memory size, index field position and base address.
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// log2 of the number of doublewords in the data array.
// 10 gives 1024 doublewords, i.e. 8 KiB.
`define DMEM_DEPTH_LOG2 10

// number of doublewords held by the array.
`define DMEM_DEPTH (1 << `DMEM_DEPTH_LOG2)

// the doubleword index sits just above the three lane bits.
`define DMEM_INDEX_LSB 3
`define DMEM_INDEX_MSB (`DMEM_INDEX_LSB + `DMEM_DEPTH_LOG2 - 1)

// byte address where the array starts in the memory map.
// upper address bits above the index are ignored by the design.
`define DMEM_BASE_ADDR 64'h0000_0000_8000_0000

`endif

/* source/mem_types_pkg.sv */
// mem types package: vector types for addresses, data, masks and array indices.
`include "lsu_cfg.svh"

package mem_types_pkg;

  // full 64-bit byte address.
  typedef logic [63:0] addr_t;

  // one doubleword of data.
  typedef logic [63:0] dword_t;

  // one write-enable bit per byte lane.
  typedef logic [7:0] wmask_t;

  // byte offset inside a doubleword.
  typedef logic [2:0] lane_t;

  // doubleword index into the array.
  typedef logic [`DMEM_DEPTH_LOG2-1:0] dmem_index_t;

endpackage

/* source/lsu_op_pkg.sv */
// lsu op package: memory operation code type and the named operation codes.
package lsu_op_pkg;

  // 3-bit operation code.
  // bits [2:1] give the size, bit 0 marks the unsigned variant.
  typedef logic [2:0] mem_op_t;

  // byte, sign extended.
  localparam mem_op_t OP_LB   = 3'b000;
  // byte, zero extended.
  localparam mem_op_t OP_LBU  = 3'b001;
  // half, sign extended.
  localparam mem_op_t OP_LH   = 3'b010;
  // half, zero extended.
  localparam mem_op_t OP_LHU  = 3'b011;
  // word, sign extended.
  localparam mem_op_t OP_LW   = 3'b100;
  // word, zero extended.
  localparam mem_op_t OP_LWU  = 3'b101;
  // full doubleword.
  localparam mem_op_t OP_LD   = 3'b110;
  // no access; strobes are ignored.
  localparam mem_op_t OP_NONE = 3'b111;

  // stores reuse the same codes.
  // the signed and unsigned variants only differ on loads.

endpackage

/* source/dmem_if.sv */
// data memory interface: array request and returned read data.
`timescale 1ns/10ps

interface dmem_if;

  // doubleword index, used for both write and read.
  mem_types_pkg::dmem_index_t index;

  // write strobe, already qualified by the operation.
  logic wr_en;

  // byte lanes to write, already shifted to the addressed offset.
  mem_types_pkg::wmask_t wmask;

  // store data, already shifted to the addressed offset.
  mem_types_pkg::dword_t wdata;

  // registered doubleword at the index of the previous edge.
  mem_types_pkg::dword_t rdata;

  // requester side.
  // the load path uses this view only to read rdata.
  modport req (
    output index,
    output wr_en,
    output wmask,
    output wdata,
    input  rdata
  );

  // memory side.
  modport mem (
    input  index,
    input  wr_en,
    input  wmask,
    input  wdata,
    output rdata
  );

endinterface

/* source/store_align.sv */
// store aligner: turns op and address into a lane-shifted byte mask and store data.
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module store_align (
  input  mem_types_pkg::addr_t   i_addr,
  input  mem_types_pkg::dword_t  i_wdata,
  input  lsu_op_pkg::mem_op_t    i_mem_op,
  input  logic                   i_wr_en,
  dmem_if.req                    o_bus
);

  // byte offset of the access inside its doubleword.
  mem_types_pkg::lane_t lane;

  // mask of the access size, before shifting.
  mem_types_pkg::wmask_t size_mask;

  assign lane = i_addr[2:0];

  // size decode.
  // signed and unsigned codes share a size.
  always_comb begin
    case (i_mem_op)
      lsu_op_pkg::OP_LB,
      lsu_op_pkg::OP_LBU: size_mask = 8'b0000_0001;
      lsu_op_pkg::OP_LH,
      lsu_op_pkg::OP_LHU: size_mask = 8'b0000_0011;
      lsu_op_pkg::OP_LW,
      lsu_op_pkg::OP_LWU: size_mask = 8'b0000_1111;
      lsu_op_pkg::OP_LD:  size_mask = 8'b1111_1111;
      default:            size_mask = 8'b0000_0000;
    endcase
  end

  // doubleword index from the address.
  // bits above the array size are dropped.
  assign o_bus.index = i_addr[`DMEM_INDEX_MSB:`DMEM_INDEX_LSB];

  // no write for the no-access code.
  assign o_bus.wr_en = i_wr_en && (i_mem_op != lsu_op_pkg::OP_NONE);

  // move the mask onto the addressed lanes.
  // accesses that cross a doubleword are undefined; upper bits fall off.
  assign o_bus.wmask = size_mask << lane;

  // move the data the same way, eight bits per lane.
  assign o_bus.wdata = i_wdata << {lane, 3'b000};

endmodule

/* source/load_extend.sv */
// load extender: holds a load for one cycle, then picks and extends the returned lane.
`timescale 1ns/10ps

module load_extend (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_rd_en,
  input  logic                   i_wr_en,
  input  lsu_op_pkg::mem_op_t    i_mem_op,
  input  mem_types_pkg::lane_t   i_lane,
  dmem_if.req                    i_bus,
  output mem_types_pkg::dword_t  o_data,
  output logic                   o_valid
);

  // a load is taken only when no write shares the cycle.
  logic load_req;

  // stage register.
  logic                  valid_q;
  lsu_op_pkg::mem_op_t   op_q;
  mem_types_pkg::lane_t  lane_q;

  // returned word with the addressed lane moved to bit 0.
  mem_types_pkg::dword_t lane_data;

  // write wins over read and the no-access code gives nothing.
  assign load_req = i_rd_en && !i_wr_en && (i_mem_op != lsu_op_pkg::OP_NONE);

  // stage valid bit.
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= load_req;
    end
  end

  // op and lane of the accepted load.
  always_ff @(posedge i_clk) begin
    if (load_req) begin
      op_q   <= i_mem_op;
      lane_q <= i_lane;
    end
  end

  // the array read lands at the same edge as the stage register.
  assign lane_data = i_bus.rdata >> {lane_q, 3'b000};

  // extend by size and signedness.
  always_comb begin
    case (op_q)
      lsu_op_pkg::OP_LB:  o_data = {{56{lane_data[7]}}, lane_data[7:0]};
      lsu_op_pkg::OP_LBU: o_data = {56'd0, lane_data[7:0]};
      lsu_op_pkg::OP_LH:  o_data = {{48{lane_data[15]}}, lane_data[15:0]};
      lsu_op_pkg::OP_LHU: o_data = {48'd0, lane_data[15:0]};
      lsu_op_pkg::OP_LW:  o_data = {{32{lane_data[31]}}, lane_data[31:0]};
      lsu_op_pkg::OP_LWU: o_data = {32'd0, lane_data[31:0]};
      // doubleword is lane 0, so the whole word passes.
      default:            o_data = lane_data;
    endcase
  end

  // one-cycle pulse per accepted load.
  assign o_valid = valid_q;

endmodule

/* source/dmem_array.sv */
// data array: byte-masked doubleword storage with a registered write-first read.
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module dmem_array (
  input  logic  i_clk,
  dmem_if.mem   i_bus
);

  // storage of one doubleword per index.
  mem_types_pkg::dword_t mem [`DMEM_DEPTH];

  // word currently stored at the index.
  mem_types_pkg::dword_t cur_word;

  // same word with this cycle's write merged in.
  mem_types_pkg::dword_t next_word;

  assign cur_word = mem[i_bus.index];

  // replace each enabled byte lane with the store data.
  always_comb begin
    next_word = cur_word;
    for (int lane = 0; lane < 8; lane++) begin
      if (i_bus.wr_en && i_bus.wmask[lane]) begin
        next_word[lane*8 +: 8] = i_bus.wdata[lane*8 +: 8];
      end
    end
  end

  // write the merged word back.
  always_ff @(posedge i_clk) begin
    if (i_bus.wr_en) begin
      mem[i_bus.index] <= next_word;
    end
  end

  // read every cycle from the merged word.
  // a load right behind a store at this edge sees the new bytes.
  always_ff @(posedge i_clk) begin
    i_bus.rdata <= next_word;
  end

endmodule

/* source/lsu_top.sv */
// lsu top: data-memory load/store path joining aligner, array and extender.
`timescale 1ns/10ps

module lsu_top (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  mem_types_pkg::addr_t   i_addr,
  input  mem_types_pkg::dword_t  i_wdata,
  input  lsu_op_pkg::mem_op_t    i_mem_op,
  input  logic                   i_wr_en,
  input  logic                   i_rd_en,
  output mem_types_pkg::dword_t  o_data,
  output logic                   o_valid
);

  // array request and read data.
  dmem_if u_dmem_if ();

  // store side.
  // also drives the shared index used for reads.
  store_align u_store_align (
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .i_mem_op (i_mem_op),
    .i_wr_en  (i_wr_en),
    .o_bus    (u_dmem_if.req)
  );

  // storage.
  // registers the addressed word every cycle.
  dmem_array u_dmem_array (
    .i_clk (i_clk),
    .i_bus (u_dmem_if.mem)
  );

  // load side.
  // only reads rdata from the interface.
  // lane offset comes straight from the low address bits.
  load_extend u_load_extend (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_rd_en  (i_rd_en),
    .i_wr_en  (i_wr_en),
    .i_mem_op (i_mem_op),
    .i_lane   (i_addr[2:0]),
    .i_bus    (u_dmem_if.req),
    .o_data   (o_data),
    .o_valid  (o_valid)
  );

endmodule

/* verif/lsu_checker.sv */
// lsu checker: keeps a byte shadow of the data array and compares every load result.
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module lsu_checker (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  mem_types_pkg::addr_t   i_addr,
  input  mem_types_pkg::dword_t  i_wdata,
  input  lsu_op_pkg::mem_op_t    i_mem_op,
  input  logic                   i_wr_en,
  input  logic                   i_rd_en,
  input  mem_types_pkg::dword_t  i_data,
  input  logic                   i_valid,
  input  logic                   i_exp_check,
  input  mem_types_pkg::dword_t  i_exp_data,
  output int                     o_loads,
  output int                     o_data_errors,
  output int                     o_other_errors,
  output int                     o_pending
);

  // one byte per offset inside the array.
  logic [7:0] shadow [int];

  // loads waiting for o_valid, oldest first.
  mem_types_pkg::dword_t pred_q [$];
  mem_types_pkg::dword_t exp_q [$];
  logic                  chk_q [$];
  logic                  known_q [$];
  mem_types_pkg::addr_t  addr_q [$];

  int loads = 0;
  int data_errors = 0;
  int other_errors = 0;
  int pushed = 0;
  int popped = 0;

  assign o_loads = loads;
  assign o_data_errors = data_errors;
  assign o_other_errors = other_errors;
  assign o_pending = pushed - popped;

  // offset of a byte address inside the array; upper bits wrap.
  function automatic int byte_key(input mem_types_pkg::addr_t a);
    return int'(a[`DMEM_INDEX_MSB:0]);
  endfunction

  // bytes touched by an operation code.
  function automatic int op_size(input lsu_op_pkg::mem_op_t op);
    return 1 << op[2:1];
  endfunction

  task automatic write_shadow(input mem_types_pkg::addr_t a, input mem_types_pkg::dword_t d,
                              input lsu_op_pkg::mem_op_t op);
    for (int b = 0; b < op_size(op); b++) begin
      shadow[byte_key(a) + b] = d[b*8 +: 8];
    end
  endtask

  // assemble the loaded bytes, low byte first, then extend.
  task automatic predict_load(input mem_types_pkg::addr_t a, input lsu_op_pkg::mem_op_t op,
                              output mem_types_pkg::dword_t value, output logic known);
    int n;
    n = op_size(op);
    value = '0;
    known = 1'b1;
    for (int b = 0; b < n; b++) begin
      if (shadow.exists(byte_key(a) + b)) begin
        value[b*8 +: 8] = shadow[byte_key(a) + b];
      end else begin
        known = 1'b0;
      end
    end
    // even codes are signed, so copy the top bit upward
    if (!op[0] && n < 8 && value[n*8-1]) begin
      for (int b = n; b < 8; b++) begin
        value[b*8 +: 8] = 8'hff;
      end
    end
  endtask

  // requests are taken at the rising edge, results checked at the falling edge.
  always begin : watch
    mem_types_pkg::dword_t pred;
    mem_types_pkg::dword_t expect_val;
    mem_types_pkg::addr_t  a;
    logic                  known;
    logic                  chk;
    @(posedge i_clk);
    if (i_wr_en && i_mem_op != lsu_op_pkg::OP_NONE) begin
      write_shadow(i_addr, i_wdata, i_mem_op);
    end else if (i_rst && i_rd_en && !i_wr_en && i_mem_op != lsu_op_pkg::OP_NONE) begin
      predict_load(i_addr, i_mem_op, pred, known);
      if (!known) begin
        $display("load at %h reads bytes that were never stored", i_addr);
        other_errors++;
      end
      pred_q.push_back(pred);
      exp_q.push_back(i_exp_data);
      chk_q.push_back(i_exp_check);
      known_q.push_back(known);
      addr_q.push_back(i_addr);
      pushed++;
    end
    @(negedge i_clk);
    if (pred_q.size() > 0) begin
      pred = pred_q.pop_front();
      expect_val = exp_q.pop_front();
      chk = chk_q.pop_front();
      known = known_q.pop_front();
      a = addr_q.pop_front();
      popped++;
      if (i_valid !== 1'b1) begin
        $display("o_valid did not come one cycle after the load at %h", a);
        other_errors++;
      end else begin
        loads++;
        if (known && i_data !== pred) begin
          $display("FAILED at %0t ns: load at %h returned %h, shadow memory gives %h",
                   $time, a, i_data, pred);
          data_errors++;
        end
        if (chk && i_data !== expect_val) begin
          $display("FAILED at %0t ns: load at %h returned %h, vector file gives %h",
                   $time, a, i_data, expect_val);
          data_errors++;
        end
      end
    end else if (i_valid !== 1'b0) begin
      $display("o_valid was high at %0t ns with no load outstanding", $time);
      other_errors++;
    end
  end

endmodule

/* verif/tb_lsu_top.sv */
// lsu testbench: clock, reset, directed vectors from file, random operations and watchdog.
`timescale 1ns/10ps
`include "lsu_cfg.svh"

module tb_lsu_top;

  // table size, random phase length and reset length in cycles.
  localparam int MAX_VEC = 64;
  localparam int RAND_WORDS = 32;
  localparam int RAND_OPS = 400;
  localparam int RESET_CYCLES = 8;

  logic                  clk;
  logic                  rst;
  mem_types_pkg::addr_t  addr;
  mem_types_pkg::dword_t wdata;
  lsu_op_pkg::mem_op_t   mem_op;
  logic                  wr_en;
  logic                  rd_en;
  mem_types_pkg::dword_t rd_data;
  logic                  rd_valid;

  // expected result of a directed load, sent along with the request.
  logic                  exp_check;
  mem_types_pkg::dword_t exp_data;

  // each vector is four words of ctrl, address offset, store data and expected result.
  logic [63:0] vec_mem [0:4*MAX_VEC-1];
  int          vec_count = 0;
  int          setup_errors = 0;

  int loads;
  int data_errors;
  int other_errors;
  int pending;

  // 8 ns period.
  always #4 clk = ~clk;

  lsu_top u_lsu_top (
    .i_clk    (clk),
    .i_rst    (rst),
    .i_addr   (addr),
    .i_wdata  (wdata),
    .i_mem_op (mem_op),
    .i_wr_en  (wr_en),
    .i_rd_en  (rd_en),
    .o_data   (rd_data),
    .o_valid  (rd_valid)
  );

  lsu_checker u_lsu_checker (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_addr         (addr),
    .i_wdata        (wdata),
    .i_mem_op       (mem_op),
    .i_wr_en        (wr_en),
    .i_rd_en        (rd_en),
    .i_data         (rd_data),
    .i_valid        (rd_valid),
    .i_exp_check    (exp_check),
    .i_exp_data     (exp_data),
    .o_loads        (loads),
    .o_data_errors  (data_errors),
    .o_other_errors (other_errors),
    .o_pending      (pending)
  );

  // one operation per falling edge.
  task automatic drive_op(input lsu_op_pkg::mem_op_t op, input logic wr, input logic rd,
                          input mem_types_pkg::addr_t a, input mem_types_pkg::dword_t d,
                          input logic chk, input mem_types_pkg::dword_t e);
    @(negedge clk);
    mem_op = op;
    wr_en = wr;
    rd_en = rd;
    addr = a;
    wdata = d;
    exp_check = chk;
    exp_data = e;
  endtask

  initial begin : stimulus
    logic [63:0]          ctrl;
    lsu_op_pkg::mem_op_t  op;
    logic [2:0]           lane;
    int                   size;
    int                   word;
    mem_types_pkg::addr_t region;
    clk = 1'b0;
    rst = 1'b0;
    addr = `DMEM_BASE_ADDR;
    wdata = '0;
    // a load is requested all through reset and must not raise o_valid.
    mem_op = lsu_op_pkg::OP_LD;
    wr_en = 1'b0;
    rd_en = 1'b1;
    exp_check = 1'b0;
    exp_data = '0;
    void'($urandom(32'h802a_da95));
    $readmemh("verif/lsu_vectors.hex", vec_mem);
    // a ctrl word of ff ends the table.
    while (vec_count < MAX_VEC && vec_mem[4*vec_count] != 64'hff) begin
      vec_count++;
    end
    if (vec_count == 0) begin
      $display("no directed vectors were read from verif/lsu_vectors.hex");
      setup_errors++;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b1;
    rd_en = 1'b0;
    mem_op = lsu_op_pkg::OP_NONE;
    // ctrl bits [6:4] op, bit 0 write, bit 1 read, bit 2 compare with file.
    for (int n = 0; n < vec_count; n++) begin
      ctrl = vec_mem[4*n];
      drive_op(ctrl[6:4], ctrl[0], ctrl[1], `DMEM_BASE_ADDR + vec_mem[4*n+1],
               vec_mem[4*n+2], ctrl[2], vec_mem[4*n+3]);
    end
    // fill the random region so every load hits known bytes.
    region = `DMEM_BASE_ADDR + 64'h200;
    for (int w = 0; w < RAND_WORDS; w++) begin
      drive_op(lsu_op_pkg::OP_LD, 1'b1, 1'b0, region + 64'(w * 8),
               {$urandom, $urandom}, 1'b0, '0);
    end
    // random mix of size-aligned stores, loads and idle codes.
    for (int n = 0; n < RAND_OPS; n++) begin
      op = 3'($urandom);
      size = 1 << op[2:1];
      lane = 3'($urandom) & ~3'(size - 1);
      word = int'($urandom % RAND_WORDS);
      drive_op(op, ($urandom % 3) == 0, ($urandom % 4) != 0,
               region + 64'(word * 8) + 64'(lane), {$urandom, $urandom}, 1'b0, '0);
    end
    drive_op(lsu_op_pkg::OP_NONE, 1'b0, 1'b0, `DMEM_BASE_ADDR, '0, 1'b0, '0);
    wait (pending == 0);
    @(negedge clk);
    $display("loads checked %0d, data errors %0d, other errors %0d, setup errors %0d",
             loads, data_errors, other_errors, setup_errors);
    if (data_errors + other_errors + setup_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // limit is twice the cycles the run needs.
  initial begin : watchdog
    int limit_ns;
    #1;
    limit_ns = (vec_count + RAND_WORDS + RAND_OPS + RESET_CYCLES) * 8 * 2;
    #(limit_ns);
    $display("watchdog expired after %0d ns before all operations finished", limit_ns);
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verif/lsu_vectors.hex */
// four hex words per line: ctrl addr wdata expect; ctrl = {op, flags}.
// flags bit0 write, bit1 read, bit2 compare; addr is the offset from the array base.
61 0 0123456789abcdef 0
66 0 0 0123456789abcdef
01 3 00000000000000a5 0
66 0 0 01234567a5abcdef
21 6 0000000000005aa5 0
66 0 0 5aa54567a5abcdef
41 0 00000000fedcba98 0
66 0 0 5aa54567fedcba98
11 5 0000000000000077 0
66 0 0 5aa57767fedcba98
06 5 0 0000000000000077
31 2 ffffffffffff1234 0
66 0 0 5aa577671234ba98
51 4 aaaaaaaa0badf00d 0
66 0 0 0badf00d1234ba98
61 8 f1e2d3c4b5a69788 0
06 8 0 ffffffffffffff88
06 f 0 fffffffffffffff1
16 8 0 0000000000000088
16 b 0 00000000000000b5
26 a 0 ffffffffffffb5a6
26 e 0 fffffffffffff1e2
36 8 0 0000000000009788
36 c 0 000000000000d3c4
46 8 0 ffffffffb5a69788
46 c 0 fffffffff1e2d3c4
56 c 0 00000000f1e2d3c4
71 0 ffffffffffffffff 0
66 0 0 0badf00d1234ba98
72 0 0 0
63 10 1122334455667788 0
66 10 0 1122334455667788
01 13 0000000000000099 0
66 10 0 1122334499667788
ff 0 0 0

/* tb.f */
+incdir+include
source/mem_types_pkg.sv
source/lsu_op_pkg.sv
source/dmem_if.sv
source/store_align.sv
source/load_extend.sv
source/dmem_array.sv
source/lsu_top.sv
verif/lsu_checker.sv
verif/tb_lsu_top.sv

/* Makefile */
# Verilator build and run of the lsu testbench.
TOP := tb_lsu_top

.PHONY: sim clean

sim:
	verilator --binary -f tb.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
